// ==== source/controlUnit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control unit
// Turns opcode and R-format funct bits into the
// control bundle carried to execute
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module controlUnit import frontEndPkg::*; (
   input  dataWord   instr,
   output ctrlBundle ctrl
);

   opcodeField opcode;

   assign opcode = instr[15:11];

   always_comb begin
      ctrl       = '0;                        // All flags low by default
      ctrl.aluOp = AluAdd;
      case (opcode)
         OpHalt: ctrl.halt = 1'b1;
         OpNop:  ctrl.nop  = 1'b1;
         OpJ: begin
            ctrl.jump = 1'b1;
         end
         OpJr: begin
            ctrl.jump = 1'b1;
            ctrl.jr   = 1'b1;                 // Target from rs
         end
         OpJal: begin
            ctrl.jump     = 1'b1;
            ctrl.jal      = 1'b1;
            ctrl.regWrite = 1'b1;             // Link into r7
         end
         OpAddi, OpSubi, OpXori, OpAndni: begin
            ctrl.aluSrc   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = {2'b00, opcode[1:0]};  // Same order as funct
         end
         OpBeqz, OpBnez: begin
            ctrl.branch = 1'b1;
            ctrl.aluOp  = AluPassA;           // Rs tested against zero
         end
         OpSt: begin
            ctrl.memWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;             // Base plus offset
         end
         OpLd: begin
            ctrl.memRead  = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         OpLbi: begin
            ctrl.aluSrc   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = AluPassB;         // Immediate straight out
         end
         OpRType: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = {2'b00, instr[1:0]};  // Funct picks the op
         end
         default: ctrl.nop = 1'b1;            // Unknown opcode
      endcase
   end

endmodule

// ==== source/decodeStage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage
// Pops packets, reads registers, extends immediates,
// resolves branches and jumps and registers the record
// handed to execute
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module decodeStage import frontEndPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        popValid,
   input  fetchPacket  popPkt,
   output logic        popReady,
   output logic        redirect,
   output dataWord     redirectPc,
   output logic        haltSeen,
   output logic        decValid,
   output decodedInstr decInstr,
   input  logic        exReady,
   input  logic        wbEn,
   input  regIdx       wbReg,
   input  dataWord     wbData
);

   dataWord     instr;
   opcodeField  opcode;
   ctrlBundle   ctrl;
   dataWord     rsData;
   dataWord     rtData;
   dataWord     immed;
   regIdx       wrReg;
   logic        pop;
   logic        taken;
   logic        haltLatched;
   decodedInstr nextRec;

   assign instr  = popPkt.instr;
   assign opcode = instr[15:11];

   controlUnit iCtrl (
      .instr (instr),
      .ctrl  (ctrl)
   );

   regFile iRegs (
      .clk    (clk),
      .rst    (rst),
      .rsSel  (instr[10:8]),
      .rtSel  (instr[7:5]),
      .rsData (rsData),
      .rtData (rtData),
      .wrEn   (wbEn),                         // Writeback from outside
      .wrSel  (wbReg),
      .wrData (wbData)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Handshake
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign popReady = ~haltLatched & (~decValid | exReady);  // Output slot frees up
   assign pop      = popValid & popReady;

   always_comb begin
      if (opcode == OpRType)    wrReg = instr[4:2];
      else if (ctrl.jal)        wrReg = LinkReg;
      else if (opcode == OpLbi) wrReg = instr[10:8];
      else                      wrReg = instr[7:5];
   end

   always_comb begin
      case (opcode)
         OpAddi, OpSubi, OpSt, OpLd:  immed = {{11{instr[4]}}, instr[4:0]};
         OpXori, OpAndni:             immed = {11'b0, instr[4:0]};  // Logical ops
         OpBeqz, OpBnez, OpJr, OpLbi: immed = {{8{instr[7]}}, instr[7:0]};
         OpJ, OpJal:                  immed = {{5{instr[10]}}, instr[10:0]};
         default:                     immed = '0;
      endcase
   end

   // Branch and jump resolution
   assign taken      = (opcode == OpBeqz) ? (rsData == '0) : (rsData != '0);
   assign redirect   = pop & (ctrl.jump | (ctrl.branch & taken));
   assign redirectPc = ctrl.jr ? (rsData + immed) : (popPkt.pcPlus2 + immed);
   assign haltSeen   = pop & ctrl.halt;

   always_comb begin
      nextRec.pc      = popPkt.pc;
      nextRec.pcPlus2 = popPkt.pcPlus2;
      nextRec.ctrl    = ctrl;
      nextRec.immed   = immed;
      nextRec.rsData  = rsData;
      nextRec.rtData  = rtData;
      nextRec.wrReg   = wrReg;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Output register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (rst) begin
         decValid    <= 1'b0;
         haltLatched <= 1'b0;
      end else begin
         if (pop) begin
            decValid <= 1'b1;
         end else if (exReady) begin
            decValid <= 1'b0;                 // Record taken, nothing behind
         end
         if (haltSeen) begin
            haltLatched <= 1'b1;              // No more pops until reset
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         decInstr <= nextRec;
      end
   end

endmodule

// ==== source/fetchUnit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch unit
// Holds the pc, reads instruction memory and pushes
// fetch packets into the queue until HALT is decoded
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fetchUnit import frontEndPkg::*; (
   input  logic       clk,
   input  logic       rst,
   output dataWord    imemAddr,
   input  dataWord    imemData,
   output logic       pushValid,
   output fetchPacket pushPkt,
   input  logic       pushReady,
   input  logic       redirect,
   input  dataWord    redirectPc,
   input  logic       haltSeen,
   output logic       halted
);

   fetchState state;
   dataWord   pc;
   dataWord   pcPlus2;
   logic      pushFire;

   assign pcPlus2   = pc + 16'd2;
   assign imemAddr  = pc;                     // Memory answers same cycle
   assign pushValid = (state == FetchRun);    // Offer a packet every run cycle
   assign halted    = (state == FetchHalted);
   assign pushFire  = pushValid & pushReady;

   always_comb begin
      pushPkt.pc      = pc;
      pushPkt.pcPlus2 = pcPlus2;
      pushPkt.instr   = imemData;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= FetchRun;
         pc    <= ResetPc;
      end else begin
         case (state)
            FetchRun: begin
               if (haltSeen) begin
                  state <= FetchHalted;       // Pc stays frozen
               end else if (redirect) begin
                  pc <= redirectPc;           // Wins over sequential step
               end else if (pushFire) begin
                  pc <= pcPlus2;
               end
            end
            FetchHalted: state <= FetchHalted;  // Only reset leaves
            default:     state <= FetchRun;
         endcase
      end
   end

endmodule

// ==== source/frontEnd.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Front end top
// Fetch unit, instruction queue and decode stage
// joined by valid/ready links
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module frontEnd import frontEndPkg::*; (
   input  logic        clk,
   input  logic        rst,
   output dataWord     imemAddr,
   input  dataWord     imemData,
   output logic        decValid,
   output decodedInstr decInstr,
   input  logic        exReady,
   input  logic        wbEn,
   input  regIdx       wbReg,
   input  dataWord     wbData,
   output logic        halted
);

   logic       pushValid;
   fetchPacket pushPkt;
   logic       pushReady;
   logic       popValid;
   fetchPacket popPkt;
   logic       popReady;
   logic       redirect;                      // Also flushes the queue
   dataWord    redirectPc;
   logic       haltSeen;

   fetchUnit iFetch (
      .clk        (clk),
      .rst        (rst),
      .imemAddr   (imemAddr),
      .imemData   (imemData),
      .pushValid  (pushValid),
      .pushPkt    (pushPkt),
      .pushReady  (pushReady),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .haltSeen   (haltSeen),
      .halted     (halted)
   );

   instrQueue iQueue (
      .clk       (clk),
      .rst       (rst),
      .flush     (redirect),
      .pushValid (pushValid),
      .pushPkt   (pushPkt),
      .pushReady (pushReady),
      .popValid  (popValid),
      .popPkt    (popPkt),
      .popReady  (popReady)
   );

   decodeStage iDecode (
      .clk        (clk),
      .rst        (rst),
      .popValid   (popValid),
      .popPkt     (popPkt),
      .popReady   (popReady),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .haltSeen   (haltSeen),
      .decValid   (decValid),
      .decInstr   (decInstr),
      .exReady    (exReady),
      .wbEn       (wbEn),
      .wbReg      (wbReg),
      .wbData     (wbData)
   );

endmodule

// ==== source/frontEndPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Front end package
// Widths, opcodes, ALU selects and the records passed
// between fetch, instruction queue and decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package frontEndPkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Vector types
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef logic [15:0] dataWord;     // Instr, address or reg data
   typedef logic [2:0]  regIdx;       // One of eight registers
   typedef logic [4:0]  opcodeField;  // Instr bits 15..11
   typedef logic [3:0]  aluOpCode;    // Op select for execute
   typedef logic [1:0]  queuePtr;     // Slot index into the queue
   typedef logic [2:0]  queueCount;   // Occupancy, 0..QueueDepth

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Opcodes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam opcodeField OpHalt  = 5'b00000;
   localparam opcodeField OpNop   = 5'b00001;
   localparam opcodeField OpJ     = 5'b00100;
   localparam opcodeField OpJr    = 5'b00101;
   localparam opcodeField OpJal   = 5'b00110;
   localparam opcodeField OpAddi  = 5'b01000;
   localparam opcodeField OpSubi  = 5'b01001;
   localparam opcodeField OpXori  = 5'b01010;
   localparam opcodeField OpAndni = 5'b01011;
   localparam opcodeField OpBeqz  = 5'b01100;
   localparam opcodeField OpBnez  = 5'b01101;
   localparam opcodeField OpSt    = 5'b10000;
   localparam opcodeField OpLd    = 5'b10001;
   localparam opcodeField OpLbi   = 5'b11000;
   localparam opcodeField OpRType = 5'b11011;

   // ALU selects, low four match R-format funct
   localparam aluOpCode AluAdd   = 4'h0;
   localparam aluOpCode AluSub   = 4'h1;
   localparam aluOpCode AluXor   = 4'h2;
   localparam aluOpCode AluAndn  = 4'h3;
   localparam aluOpCode AluPassA = 4'h4;  // Rs through, branch test
   localparam aluOpCode AluPassB = 4'h5;  // Immediate through, LBI

   localparam int      QueueDepth = 4;
   localparam dataWord ResetPc    = 16'h0000;
   localparam regIdx   LinkReg    = 3'd7;  // JAL return address

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Pipeline records
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef struct packed {
      dataWord pc;
      dataWord pcPlus2;
      dataWord instr;
   } fetchPacket;                          // 48 bits

   typedef struct packed {
      logic     halt;
      logic     nop;
      logic     jal;
      logic     jr;
      logic     jump;                      // J, JR and JAL
      logic     branch;                    // BEQZ and BNEZ
      logic     memToReg;
      logic     memRead;
      logic     memWrite;
      logic     aluSrc;                    // Immediate as operand B
      logic     regWrite;
      aluOpCode aluOp;
   } ctrlBundle;

   typedef struct packed {
      dataWord   pc;
      dataWord   pcPlus2;
      ctrlBundle ctrl;
      dataWord   immed;
      dataWord   rsData;
      dataWord   rtData;
      regIdx     wrReg;
   } decodedInstr;

   typedef enum logic {
      FetchRun,
      FetchHalted
   } fetchState;

endpackage

// ==== source/instrQueue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction queue
// Circular FIFO of fetch packets between fetch and
// decode, emptied by a redirect flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module instrQueue import frontEndPkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       flush,
   input  logic       pushValid,
   input  fetchPacket pushPkt,
   output logic       pushReady,
   output logic       popValid,
   output fetchPacket popPkt,
   input  logic       popReady
);

   fetchPacket slots [QueueDepth];
   queuePtr    wrPtr;
   queuePtr    rdPtr;
   queueCount  count;
   logic       doPush;
   logic       doPop;

   assign pushReady = (count != queueCount'(QueueDepth));  // Not full
   assign popValid  = (count != '0);                       // Not empty
   assign popPkt    = slots[rdPtr];                        // Head of queue

   // Flush drops the push and the pop of its edge
   assign doPush = pushValid & pushReady & ~flush;
   assign doPop  = popValid & popReady & ~flush;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Pointers and occupancy
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doPush) begin
            wrPtr <= wrPtr + 2'd1;            // Wraps at depth 4
         end
         if (doPop) begin
            rdPtr <= rdPtr + 2'd1;
         end
         count <= count + queueCount'(doPush) - queueCount'(doPop);
      end
   end

   // Packet storage
   always_ff @(posedge clk) begin
      if (doPush) begin
         slots[wrPtr] <= pushPkt;
      end
   end

endmodule

// ==== source/regFile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file
// Eight 16-bit registers, two read ports, one write
// port, write data bypassed to the reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module regFile import frontEndPkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  regIdx   rsSel,
   input  regIdx   rtSel,
   output dataWord rsData,
   output dataWord rtData,
   input  logic    wrEn,
   input  regIdx   wrSel,
   input  dataWord wrData
);

   dataWord regs [2**$bits(regIdx)];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 2**$bits(regIdx); i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrSel] <= wrData;
      end
   end

   // Same-cycle write shows up on the read
   assign rsData = (wrEn && (wrSel == rsSel)) ? wrData : regs[rsSel];
   assign rtData = (wrEn && (wrSel == rtSel)) ? wrData : regs[rtSel];

endmodule

// ==== tb.f ====
source/frontEndPkg.sv
source/fetchUnit.sv
source/instrQueue.sv
source/controlUnit.sv
source/regFile.sv
source/decodeStage.sv
source/frontEnd.sv
test/frontEnd_props.sv
test/frontEndTb.sv

// ==== test/frontEndTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Front end testbench
// Instruction memory model, register prologue, reference
// decode rules and directed tests for fetch, queue and
// decode including branches, jumps and halt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module frontEndTb import frontEndPkg::*; ();

   localparam int RecordTimeout = 200;        // Cycles per decoded record
   localparam int HaltWindow    = 50;

   logic        clk;
   logic        rst;
   dataWord     imemAddr;
   dataWord     imemData;
   logic        decValid;
   decodedInstr decInstr;
   logic        exReady;
   logic        wbEn;
   regIdx       wbReg;
   dataWord     wbData;
   logic        halted;

   dataWord     imem [256];                   // Word array indexed by addr / 2
   dataWord     regVal [8];                   // Shadow of prologue writes
   logic [31:0] lfsrState;
   string       testName;

   frontEnd uut (
      .clk      (clk),
      .rst      (rst),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .decValid (decValid),
      .decInstr (decInstr),
      .exReady  (exReady),
      .wbEn     (wbEn),
      .wbReg    (wbReg),
      .wbData   (wbData),
      .halted   (halted)
   );

   assign imemData = imem[imemAddr[8:1]];     // Combinational read

   always #20 clk = ~clk;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reporting
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic stopOnError(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkValue(input string label, input logic [127:0] expected,
                             input logic [127:0] actual);
      if (actual !== expected) begin
         stopOnError($sformatf("ERROR %s %s: expected %0h, actual %0h",
                               testName, label, expected, actual));
      end
   endtask

   // Bound assertion failures end the run at once
   always @(negedge clk) begin
      if (uut.iQueue.queueProps.failCount != 0 ||
          uut.iDecode.decodeProps.failCount != 0) begin
         stopOnError("a bound assertion on the queue or decode stage failed");
      end
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic lfsrStep();
      logic fb;
      fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      return fb;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Instruction encoders
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic dataWord shortImmForm(input opcodeField op, input regIdx rs,
                                            input regIdx rt, input logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic dataWord longImmForm(input opcodeField op, input regIdx rs,
                                           input logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic dataWord jumpForm(input opcodeField op, input logic [10:0] off);
      return {op, off};
   endfunction

   function automatic dataWord regForm(input regIdx rs, input regIdx rt, input regIdx rd,
                                       input logic [1:0] funct);
      return {OpRType, rs, rt, rd, funct};
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference decode rules
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic decodedInstr expectedRecord(input dataWord pc, input dataWord instr);
      decodedInstr rec;
      opcodeField  op;
      op             = instr[15:11];
      rec            = '0;
      rec.pc         = pc;
      rec.pcPlus2    = pc + 16'd2;
      rec.rsData     = regVal[instr[10:8]];
      rec.rtData     = regVal[instr[7:5]];
      rec.wrReg      = instr[7:5];            // Default destination
      rec.ctrl.aluOp = AluAdd;
      case (op)
         OpHalt: rec.ctrl.halt = 1'b1;
         OpNop:  rec.ctrl.nop  = 1'b1;
         OpJ, OpJal: begin
            rec.ctrl.jump = 1'b1;
            rec.immed     = {{5{instr[10]}}, instr[10:0]};
            if (op == OpJal) begin
               rec.ctrl.jal      = 1'b1;
               rec.ctrl.regWrite = 1'b1;
               rec.wrReg         = LinkReg;
            end
         end
         OpJr: begin
            rec.ctrl.jump = 1'b1;
            rec.ctrl.jr   = 1'b1;
            rec.immed     = {{8{instr[7]}}, instr[7:0]};
         end
         OpAddi, OpSubi, OpXori, OpAndni: begin
            rec.ctrl.aluSrc   = 1'b1;
            rec.ctrl.regWrite = 1'b1;
            rec.ctrl.aluOp    = aluOpCode'(op - OpAddi);  // Add, sub, xor, andn
            if (op == OpXori || op == OpAndni) rec.immed = {11'b0, instr[4:0]};
            else                               rec.immed = {{11{instr[4]}}, instr[4:0]};
         end
         OpBeqz, OpBnez: begin
            rec.ctrl.branch = 1'b1;
            rec.ctrl.aluOp  = AluPassA;
            rec.immed       = {{8{instr[7]}}, instr[7:0]};
         end
         OpSt, OpLd: begin
            rec.ctrl.aluSrc = 1'b1;
            rec.immed       = {{11{instr[4]}}, instr[4:0]};
            if (op == OpSt) begin
               rec.ctrl.memWrite = 1'b1;
            end else begin
               rec.ctrl.memRead  = 1'b1;
               rec.ctrl.memToReg = 1'b1;
               rec.ctrl.regWrite = 1'b1;
            end
         end
         OpLbi: begin
            rec.ctrl.aluSrc   = 1'b1;
            rec.ctrl.regWrite = 1'b1;
            rec.ctrl.aluOp    = AluPassB;
            rec.immed         = {{8{instr[7]}}, instr[7:0]};
            rec.wrReg         = instr[10:8];
         end
         OpRType: begin
            rec.ctrl.regWrite = 1'b1;
            rec.ctrl.aluOp    = {2'b00, instr[1:0]};
            rec.wrReg         = instr[4:2];
         end
         default: rec.ctrl.nop = 1'b1;
      endcase
      return rec;
   endfunction

   // Pc of the next delivered record
   function automatic dataWord followingPc(input dataWord pc, input dataWord instr);
      dataWord rs;
      dataWord off8;
      rs   = regVal[instr[10:8]];
      off8 = {{8{instr[7]}}, instr[7:0]};
      case (instr[15:11])
         OpBeqz:     return (rs == '0) ? pc + 16'd2 + off8 : pc + 16'd2;
         OpBnez:     return (rs != '0) ? pc + 16'd2 + off8 : pc + 16'd2;
         OpJ, OpJal: return pc + 16'd2 + {{5{instr[10]}}, instr[10:0]};
         OpJr:       return rs + off8;
         default:    return pc + 16'd2;
      endcase
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // DUT drivers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // LBI r0 fill with the full word index followed by five NOPs
   task automatic initMemory();
      for (int i = 0; i < 256; i++) begin
         imem[i] = longImmForm(OpLbi, 3'd0, 8'(i));
      end
      for (int i = 0; i < 5; i++) begin
         imem[i] = {OpNop, 11'b0};
      end
   endtask

   task automatic resetDut();
      @(negedge clk);
      rst     = 1'b1;
      exReady = 1'b0;
      wbEn    = 1'b0;
      wbReg   = '0;
      wbData  = '0;
      repeat (8) @(negedge clk);
      checkValue("decValid in reset", 1'b0, decValid);
      checkValue("halted in reset", 1'b0, halted);
      checkValue("imemAddr in reset", ResetPc, imemAddr);
      rst = 1'b0;
   endtask

   // Runs while the NOPs stall with exReady low
   task automatic writeRegs();
      regVal[0] = 16'h0000;
      regVal[1] = 16'h0005;
      regVal[2] = 16'hfff0;
      regVal[3] = 16'h1234;
      regVal[4] = 16'h0000;
      regVal[5] = 16'h00a0;                   // JR base
      regVal[6] = 16'h8001;
      regVal[7] = 16'h0077;
      for (int i = 0; i < 8; i++) begin
         @(negedge clk);
         wbEn   = 1'b1;
         wbReg  = regIdx'(i);
         wbData = regVal[i];
      end
      @(negedge clk);
      wbEn = 1'b0;
   endtask

   // Takes one record off the output with exReady set each falling edge
   task automatic nextRecord(output decodedInstr rec, input bit randomReady);
      int waited;
      bit got;
      waited = 0;
      got    = 1'b0;
      while (!got) begin
         @(negedge clk);
         exReady = randomReady ? lfsrStep() : 1'b1;
         if (decValid && exReady) begin
            rec = decInstr;                   // Transfers at the next rising edge
            got = 1'b1;
         end else if (waited >= RecordTimeout) begin
            stopOnError($sformatf("%s: no decoded record within %0d cycles",
                                  testName, RecordTimeout));
         end
         waited++;
      end
   endtask

   // Walks the program from ResetPc along the reference pc sequence
   task automatic followProgram(input int count, input bit randomReady);
      dataWord     pc;
      dataWord     instr;
      decodedInstr rec;
      pc = ResetPc;
      for (int n = 0; n < count; n++) begin
         instr = imem[pc[8:1]];
         nextRecord(rec, randomReady);
         checkValue("pc", pc, rec.pc);
         checkValue($sformatf("record at pc %0h", pc), expectedRecord(pc, instr), rec);
         if (instr[15:11] == OpJal) begin
            checkValue("jal regWrite", 1'b1, rec.ctrl.regWrite);
            checkValue("jal wrReg", LinkReg, rec.wrReg);
         end
         pc = followingPc(pc, instr);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Directed tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic straightLineDecode();
      testName = "straightLine";
      initMemory();
      imem[5]  = shortImmForm(OpAddi, 3'd1, 3'd2, 5'h1d);   // Negative immediate
      imem[6]  = shortImmForm(OpSubi, 3'd3, 3'd6, 5'h07);
      imem[7]  = shortImmForm(OpXori, 3'd3, 3'd4, 5'h1d);   // Zero extended
      imem[8]  = shortImmForm(OpAndni, 3'd6, 3'd1, 5'h12);
      imem[9]  = shortImmForm(OpLd, 3'd6, 3'd5, 5'h04);
      imem[10] = shortImmForm(OpSt, 3'd2, 3'd3, 5'h1f);
      imem[11] = longImmForm(OpLbi, 3'd1, 8'h9c);
      imem[12] = regForm(3'd1, 3'd3, 3'd6, 2'b01);
      imem[13] = regForm(3'd2, 3'd5, 3'd4, 2'b10);
      resetDut();
      writeRegs();
      followProgram(14, 1'b0);
   endtask

   task automatic randomReadyStream();
      testName = "randomReady";
      initMemory();
      for (int k = 0; k < 20; k++) begin
         imem[5 + k] = shortImmForm(opcodeField'(OpAddi + k % 4), regIdx'(k % 8),
                                    regIdx'((k + 3) % 8), 5'(k));
      end
      resetDut();
      writeRegs();
      followProgram(25, 1'b1);
   endtask

   task automatic branchTargets();
      testName = "branches";
      initMemory();
      imem[5]  = longImmForm(OpBeqz, 3'd0, 8'd6);    // Taken to pc 18
      imem[9]  = longImmForm(OpBeqz, 3'd1, 8'd8);    // Not taken
      imem[10] = longImmForm(OpBnez, 3'd1, 8'd4);    // Taken to pc 26
      imem[13] = longImmForm(OpBnez, 3'd4, 8'd10);   // Not taken
      imem[14] = longImmForm(OpBeqz, 3'd4, 8'he8);   // Back to pc 6
      resetDut();
      writeRegs();
      followProgram(14, 1'b0);
   endtask

   task automatic jumpTargets();
      testName = "jumps";
      initMemory();
      imem[5]  = jumpForm(OpJ, 11'd8);               // To pc 20
      imem[10] = jumpForm(OpJal, 11'd20);            // To pc 42 and links r7
      imem[21] = longImmForm(OpJr, 3'd5, 8'hc0);     // r5 - 64 = pc 96
      imem[48] = jumpForm(OpJ, 11'h7f0);             // Back to pc 82
      resetDut();
      writeRegs();
      followProgram(11, 1'b0);
   endtask

   task automatic haltFreeze();
      int waited;
      testName = "halt";
      initMemory();
      imem[5] = shortImmForm(OpAddi, 3'd1, 3'd1, 5'd1);
      imem[6] = {OpHalt, 11'b0};
      resetDut();
      writeRegs();
      followProgram(7, 1'b0);                     // HALT record is the last
      waited = 0;
      while (!halted) begin
         @(negedge clk);
         if (waited >= 20) begin
            stopOnError("halt: halted did not rise after the HALT record");
         end
         waited++;
      end
      exReady = 1'b1;
      for (int n = 0; n < HaltWindow; n++) begin
         @(negedge clk);
         checkValue("decValid after halt", 1'b0, decValid);
         checkValue("halted held", 1'b1, halted);
      end
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      exReady    = 1'b0;
      wbEn       = 1'b0;
      wbReg      = '0;
      wbData     = '0;
      lfsrState  = 32'hea66b509;
      testName   = "init";
      initMemory();
      straightLineDecode();
      randomReadyStream();
      branchTargets();
      jumpTargets();
      haltFreeze();
      if (uut.iQueue.queueProps.failCount == 0 &&
          uut.iDecode.decodeProps.failCount == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== test/frontEnd_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Front end properties
// Queue occupancy, output record stability and
// redirect qualification, bound into queue and decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module frontEnd_props import frontEndPkg::*; (
   input logic        clk,
   input logic        rst,
   input queueCount   count,
   input logic        decValid,
   input decodedInstr decInstr,
   input logic        exReady,
   input logic        redirect,
   input logic        popValid
);

   int failCount = 0;                         // Assertion failures so far

   occupancyLimit: assert property (@(posedge clk) disable iff (rst)
      count <= queueCount'(QueueDepth))
      else begin
         failCount++;
         $error("queue occupancy above its depth");
      end

   // Stalled record must sit still
   recordStable: assert property (@(posedge clk) disable iff (rst)
      (decValid && !exReady) |=> (decValid && $stable(decInstr)))
      else begin
         failCount++;
         $error("decoded record changed while stalled");
      end

   redirectOnPop: assert property (@(posedge clk) disable iff (rst)
      redirect |-> popValid)
      else begin
         failCount++;
         $error("redirect raised with an empty queue");
      end

endmodule

// Queue side with decode ports tied idle
bind instrQueue frontEnd_props queueProps (
   .clk      (clk),
   .rst      (rst),
   .count    (count),
   .decValid (1'b0),
   .decInstr ('0),
   .exReady  (1'b1),
   .redirect (1'b0),
   .popValid (popValid)
);

// Decode side with occupancy tied to empty
bind decodeStage frontEnd_props decodeProps (
   .clk      (clk),
   .rst      (rst),
   .count    (3'd0),
   .decValid (decValid),
   .decInstr (decInstr),
   .exReady  (exReady),
   .redirect (redirect),
   .popValid (popValid)
);
